// ==== bench/load_queue_tb.sv ====
// load queue testbench: allocation, execute writes, memory returns, bypass and forward checks
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module load_queue_tb;

  logic                     i_clk;
  logic                     i_reset_n;
  logic                     i_alloc;
  logic                     i_alloc_is_load;
  logic [`LQ_RD_W-1:0]      i_alloc_rd;
  logic                     i_ex_vld;
  logic [`LQ_ID_W-1:0]      i_ex_id;
  load_queue_pkg::lq_word_u i_ex_word;
  logic                     i_ret0_vld;
  logic                     i_ret0_cancel;
  logic [`LQ_ID_W-1:0]      i_ret0_id;
  logic [`LQ_DATA_W-1:0]    i_ret0_data;
  logic                     i_ret1_vld;
  logic                     i_ret1_cancel;
  logic [`LQ_ID_W-1:0]      i_ret1_id;
  logic [`LQ_DATA_W-1:0]    i_ret1_data;
  logic                     i_bypass_disable;
  logic                     i_lq_rden;
  logic [`LQ_ID_W-1:0]      o_next_id;
  logic                     o_full;
  logic                     o_empty;
  logic [`LQ_ID_W-1:0]      o_rd_id;
  logic                     o_rd_is_load;
  logic [`LQ_RD_W-1:0]      o_rd_rd;
  logic [`LQ_DATA_W-1:0]    o_rd_data;
  logic [`LQ_EXC_W-1:0]     o_rd_exc;
  logic                     o_data_ready;
  logic                     o_fwd_vld;
  logic [`LQ_ID_W-1:0]      o_fwd_id;
  logic [`LQ_DATA_W-1:0]    o_fwd_data;

  // queue model
  load_queue_pkg::lq_word_u m_word [`LQ_DEPTH];
  logic                     m_ld   [`LQ_DEPTH];
  logic [`LQ_RD_W-1:0]      m_rd   [`LQ_DEPTH];
  logic                     m_dvld [`LQ_DEPTH];
  int                       cnt_m;
  int                       nid_m;
  int                       head_m;
  logic                     exp_byp;  // a return bypasses to the head this cycle
  logic [31:0]              exp_byp_data;
  logic                     exp_fwd;
  logic [31:0]              exp_fwd_data;
  logic                     chk_on;
  logic [31:0]              seed;
  logic [2:0]               sz_codes [6];
  int                       err_cnt;
  int                       timeout_cnt;

  load_queue i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic load_queue_pkg::lq_word_u rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi[6:0], lo};
  endfunction

  // expected load alignment
  function automatic logic [31:0] align_ref(input logic [31:0] d, input logic [2:0] sz,
                                            input logic [1:0] ofs);
    logic [31:0] b;
    logic [31:0] h;
    b = (d >> (ofs * 8)) & 32'h0000_00ff;
    h = (d >> (ofs[1] * 16)) & 32'h0000_ffff;
    case (sz)
      `SZ_SB:  return b[7] ? (b | 32'hffff_ff00) : b;
      `SZ_SH:  return h[15] ? (h | 32'hffff_0000) : h;
      `SZ_UB:  return b;
      `SZ_UH:  return h;
      `SZ_HNB: return h | 32'hffff_0000;
      default: return d;
    endcase
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
    err_cnt++;
  endtask

  // comparison against the model, sampled mid-cycle
  always @(negedge i_clk) begin
    if (chk_on) begin
      assert (o_empty == (cnt_m == 0)) else value_error("o_empty", o_empty, cnt_m == 0);
      assert (o_full == (cnt_m == `LQ_DEPTH)) else value_error("o_full", o_full, cnt_m == 8);
      assert (o_next_id == nid_m) else value_error("o_next_id", o_next_id, nid_m);
      assert (o_rd_id == head_m) else value_error("o_rd_id", o_rd_id, head_m);
      assert (o_data_ready == (m_dvld[head_m] | exp_byp))
        else value_error("o_data_ready", o_data_ready, m_dvld[head_m] | exp_byp);
      assert (o_fwd_vld == exp_fwd) else value_error("o_fwd_vld", o_fwd_vld, exp_fwd);
      if (exp_fwd) begin
        assert (o_fwd_data == exp_fwd_data) else value_error("o_fwd_data", o_fwd_data, exp_fwd_data);
        assert (o_fwd_id == head_m) else value_error("o_fwd_id", o_fwd_id, head_m);
      end
      if (cnt_m != 0) begin
        assert (o_rd_is_load == m_ld[head_m])
          else value_error("o_rd_is_load", o_rd_is_load, m_ld[head_m]);
        assert (o_rd_rd == m_rd[head_m]) else value_error("o_rd_rd", o_rd_rd, m_rd[head_m]);
      end
      if (exp_byp) begin
        assert (o_rd_data == exp_byp_data) else value_error("o_rd_data", o_rd_data, exp_byp_data);
        assert (o_rd_exc == '0) else value_error("o_rd_exc", o_rd_exc, 0);
      end else if (m_dvld[head_m]) begin
        assert (o_rd_data == m_word[head_m].res.data)
          else value_error("o_rd_data", o_rd_data, m_word[head_m].res.data);
        assert (o_rd_exc == m_word[head_m].res.exc)
          else value_error("o_rd_exc", o_rd_exc, m_word[head_m].res.exc);
      end
    end
  end

  task automatic alloc_entry(input logic ld);
    logic [31:0] r;
    r = rand32();
    @(posedge i_clk);
    i_alloc         <= 1'b1;
    i_alloc_is_load <= ld;
    i_alloc_rd      <= r[4:0];
    @(posedge i_clk);
    i_alloc <= 1'b0;
    m_ld[nid_m]   = ld;
    m_rd[nid_m]   = r[4:0];
    m_dvld[nid_m] = 1'b0;
    nid_m = (nid_m + 1) % `LQ_DEPTH;
    cnt_m++;
  endtask

  task automatic ex_write(input int id, input load_queue_pkg::lq_word_u w);
    @(posedge i_clk);
    i_ex_vld  <= 1'b1;
    i_ex_id   <= `LQ_ID_W'(id);
    i_ex_word <= w;
    @(posedge i_clk);
    i_ex_vld <= 1'b0;
    m_word[id] = w;
    if (!m_ld[id]) m_dvld[id] = 1'b1; // loads wait for memory
  endtask

  task automatic present_returns(input logic v0, input logic c0, input int id0,
                                 input logic [31:0] d0, input logic v1, input logic c1,
                                 input int id1, input logic [31:0] d1, input logic bdis);
    logic [31:0] al0;
    logic [31:0] al1;
    logic        hit0;
    logic        hit1;
    logic        byp0;
    logic        byp1;
    al0  = align_ref(d0, m_word[id0].ld.sz, m_word[id0].ld.ofs);
    al1  = align_ref(d1, m_word[id1].ld.sz, m_word[id1].ld.ofs);
    hit0 = v0 & (id0 == head_m);
    hit1 = v1 & (id1 == head_m);
    byp0 = hit0 & ~c0 & ~bdis;
    byp1 = hit1 & ~c1 & ~bdis;
    @(posedge i_clk);
    i_ret0_vld <= v0;
    i_ret0_cancel <= c0;
    i_ret0_id <= `LQ_ID_W'(id0);
    i_ret0_data <= d0;
    i_ret1_vld <= v1;
    i_ret1_cancel <= c1;
    i_ret1_id <= `LQ_ID_W'(id1);
    i_ret1_data <= d1;
    i_bypass_disable <= bdis;
    exp_byp      = byp0 | byp1;
    exp_byp_data = byp0 ? al0 : al1;
    exp_fwd      = (hit0 | hit1) & ~(c0 | c1); // late cancel from either port
    exp_fwd_data = hit0 ? al0 : al1;
    @(posedge i_clk);
    i_ret0_vld <= 1'b0;
    i_ret1_vld <= 1'b0;
    i_ret0_cancel <= 1'b0;
    i_ret1_cancel <= 1'b0;
    i_bypass_disable <= 1'b0;
    exp_byp = 1'b0;
    exp_fwd = 1'b0;
    if (v0 & ~c0 & ~byp0) begin
      m_word[id0].ld.data = al0;
      m_dvld[id0] = 1'b1;
    end
    if (v1 & ~c1 & ~byp1) begin
      m_word[id1].ld.data = al1;
      m_dvld[id1] = 1'b1;
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_data_ready && n < 20) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_data_ready) begin
      $display("timeout: head entry %0d never became ready", head_m);
      timeout_cnt++;
    end
  endtask

  task automatic read_head(input logic need_ready);
    if (need_ready) wait_ready();
    @(posedge i_clk);
    i_lq_rden <= 1'b1;
    @(posedge i_clk);
    i_lq_rden <= 1'b0;
    m_dvld[head_m] = 1'b0;
    head_m = (head_m + 1) % `LQ_DEPTH;
    cnt_m--;
  endtask

  // load word with a given size code and random offset
  function automatic load_queue_pkg::lq_word_u load_word(input logic [2:0] sz);
    load_queue_pkg::lq_word_u w;
    w = rand_word();
    w.ld.sz = sz;
    return w;
  endfunction

  initial begin : stimulus
    int ids [6];
    int blk;
    logic [31:0] r;
    seed = 32'h9bcc0823;
    err_cnt = 0;
    timeout_cnt = 0;
    chk_on = 1'b0;
    cnt_m = 0;
    nid_m = 0;
    head_m = 0;
    exp_byp = 1'b0;
    exp_fwd = 1'b0;
    exp_byp_data = '0;
    exp_fwd_data = '0;
    sz_codes = '{`SZ_SB, `SZ_SH, `SZ_W, `SZ_UB, `SZ_UH, `SZ_HNB};
    for (int i = 0; i < `LQ_DEPTH; i++) begin
      m_dvld[i] = 1'b0;
      m_ld[i] = 1'b0;
      m_rd[i] = '0;
      m_word[i] = '0;
    end
    {i_alloc, i_alloc_is_load, i_alloc_rd, i_ex_vld, i_ex_id, i_lq_rden} = '0;
    i_ex_word = '0;
    {i_ret0_vld, i_ret0_cancel, i_ret0_id, i_ret0_data} = '0;
    {i_ret1_vld, i_ret1_cancel, i_ret1_id, i_ret1_data} = '0;
    i_bypass_disable = 1'b0;
    i_reset_n = 1'b0;
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    chk_on = 1'b1;
    repeat (2) @(posedge i_clk);

    // fill to full, then drain in order
    for (int i = 0; i < `LQ_DEPTH; i++) alloc_entry(i[0]);
    for (int i = 0; i < `LQ_DEPTH; i++) read_head(1'b0);

    // non-load result through the execute port
    blk = nid_m;
    alloc_entry(1'b0);
    ex_write(blk, rand_word());
    read_head(1'b1);

    // every size code through non-head returns
    blk = nid_m;
    alloc_entry(1'b0);
    for (int k = 0; k < 6; k++) begin
      ids[k] = nid_m;
      alloc_entry(1'b1);
      ex_write(ids[k], load_word(sz_codes[k]));
    end
    for (int k = 0; k < 6; k++) begin
      r = rand32();
      present_returns(~k[0], 1'b0, ids[k], r, k[0], 1'b0, ids[k], r, 1'b0);
    end
    ex_write(blk, rand_word());
    for (int k = 0; k < 7; k++) read_head(1'b1);

    // returns to the head: bypass, own cancel, other port cancel, bypass off
    ids[0] = nid_m;
    alloc_entry(1'b1);
    ids[1] = nid_m;
    alloc_entry(1'b1);
    r = rand32();
    ex_write(ids[0], load_word(sz_codes[r % 6]));
    r = rand32();
    ex_write(ids[1], load_word(sz_codes[r % 6]));
    present_returns(1'b1, 1'b0, ids[0], rand32(), 1'b0, 1'b0, ids[1], '0, 1'b0);
    present_returns(1'b0, 1'b0, ids[1], '0, 1'b1, 1'b1, ids[0], rand32(), 1'b0);
    present_returns(1'b1, 1'b0, ids[0], rand32(), 1'b1, 1'b1, ids[1], rand32(), 1'b0);
    present_returns(1'b1, 1'b0, ids[0], rand32(), 1'b0, 1'b0, ids[1], '0, 1'b1);
    read_head(1'b1);

    // both ports to two non-head entries in one cycle
    ids[2] = nid_m;
    alloc_entry(1'b1);
    ids[3] = nid_m;
    alloc_entry(1'b1);
    ex_write(ids[2], load_word(sz_codes[0]));
    ex_write(ids[3], load_word(sz_codes[4]));
    present_returns(1'b1, 1'b0, ids[2], rand32(), 1'b1, 1'b0, ids[3], rand32(), 1'b0);
    present_returns(1'b0, 1'b0, ids[2], '0, 1'b1, 1'b0, ids[1], rand32(), 1'b1);
    for (int k = 0; k < 3; k++) read_head(1'b1);

    repeat (2) @(posedge i_clk);
    $display("checks done: %0d value errors, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // overall limit on the run
  initial begin : watchdog
    repeat (5000) @(posedge i_clk);
    $display("timeout: simulation did not reach the end of the test sequence");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== hdl/load_queue.sv ====
// scalar load queue top: pointers, entry storage, two return paths and head reader
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module load_queue (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  // allocation
  input  logic                     i_alloc,
  input  logic                     i_alloc_is_load,
  input  logic [`LQ_RD_W-1:0]      i_alloc_rd,
  // execute write
  input  logic                     i_ex_vld,
  input  logic [`LQ_ID_W-1:0]      i_ex_id,
  input  load_queue_pkg::lq_word_u i_ex_word,
  // memory returns
  input  logic                     i_ret0_vld,
  input  logic                     i_ret0_cancel,
  input  logic [`LQ_ID_W-1:0]      i_ret0_id,
  input  logic [`LQ_DATA_W-1:0]    i_ret0_data,
  input  logic                     i_ret1_vld,
  input  logic                     i_ret1_cancel,
  input  logic [`LQ_ID_W-1:0]      i_ret1_id,
  input  logic [`LQ_DATA_W-1:0]    i_ret1_data,
  // control
  input  logic                     i_bypass_disable,
  input  logic                     i_lq_rden,
  output logic [`LQ_ID_W-1:0]      o_next_id,
  output logic                     o_full,
  output logic                     o_empty,
  // head
  output logic [`LQ_ID_W-1:0]      o_rd_id,
  output logic                     o_rd_is_load,
  output logic [`LQ_RD_W-1:0]      o_rd_rd,
  output logic [`LQ_DATA_W-1:0]    o_rd_data,
  output logic [`LQ_EXC_W-1:0]     o_rd_exc,
  output logic                     o_data_ready,
  // register-file forward
  output logic                     o_fwd_vld,
  output logic [`LQ_ID_W-1:0]      o_fwd_id,
  output logic [`LQ_DATA_W-1:0]    o_fwd_data
);

  logic [`LQ_ID_W-1:0]                      rd_idx;
  logic [`LQ_DEPTH-1:0]                     entry_is_load;
  load_queue_pkg::lq_word_u [`LQ_DEPTH-1:0] entry_word;
  logic [`LQ_DEPTH-1:0][`LQ_RD_W-1:0]       entry_rd;
  logic [`LQ_DEPTH-1:0]                     entry_data_valid;

  logic [`LQ_DATA_W-1:0] ret0_aligned;
  logic                  ret0_head_hit;
  logic                  ret0_bypass;
  logic                  ret0_store;
  logic [`LQ_DATA_W-1:0] ret1_aligned;
  logic                  ret1_head_hit;
  logic                  ret1_bypass;
  logic                  ret1_store;

  lq_pointers u_pointers (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (i_alloc),
    .i_lq_rden (i_lq_rden),
    .o_wr_idx  (o_next_id),
    .o_rd_idx  (rd_idx),
    .o_full    (o_full),
    .o_empty   (o_empty)
  );

  lq_entry_array u_entries (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_alloc         (i_alloc),
    .i_wr_idx        (o_next_id),
    .i_alloc_is_load (i_alloc_is_load),
    .i_alloc_rd      (i_alloc_rd),
    .i_ex_vld        (i_ex_vld),
    .i_ex_id         (i_ex_id),
    .i_ex_word       (i_ex_word),
    .i_ret0_store    (ret0_store),
    .i_ret0_id       (i_ret0_id),
    .i_ret0_data     (ret0_aligned),
    .i_ret1_store    (ret1_store),
    .i_ret1_id       (i_ret1_id),
    .i_ret1_data     (ret1_aligned),
    .i_clear         (i_lq_rden),
    .i_rd_idx        (rd_idx),
    .o_is_load       (entry_is_load),
    .o_word          (entry_word),
    .o_rd            (entry_rd),
    .o_data_valid    (entry_data_valid)
  );

  lq_return_path u_ret0 (
    .i_vld            (i_ret0_vld),
    .i_cancel         (i_ret0_cancel),
    .i_id             (i_ret0_id),
    .i_data           (i_ret0_data),
    .i_bypass_disable (i_bypass_disable),
    .i_rd_idx         (rd_idx),
    .i_word           (entry_word[i_ret0_id]),
    .i_is_load        (entry_is_load[i_ret0_id]),
    .o_aligned        (ret0_aligned),
    .o_head_hit       (ret0_head_hit),
    .o_bypass         (ret0_bypass),
    .o_store          (ret0_store)
  );

  lq_return_path u_ret1 (
    .i_vld            (i_ret1_vld),
    .i_cancel         (i_ret1_cancel),
    .i_id             (i_ret1_id),
    .i_data           (i_ret1_data),
    .i_bypass_disable (i_bypass_disable),
    .i_rd_idx         (rd_idx),
    .i_word           (entry_word[i_ret1_id]),
    .i_is_load        (entry_is_load[i_ret1_id]),
    .o_aligned        (ret1_aligned),
    .o_head_hit       (ret1_head_hit),
    .o_bypass         (ret1_bypass),
    .o_store          (ret1_store)
  );

  lq_read_port u_read (
    .i_rd_idx        (rd_idx),
    .i_is_load       (entry_is_load),
    .i_word          (entry_word),
    .i_rd            (entry_rd),
    .i_data_valid    (entry_data_valid),
    .i_ret0_aligned  (ret0_aligned),
    .i_ret0_head_hit (ret0_head_hit),
    .i_ret0_bypass   (ret0_bypass),
    .i_ret0_cancel   (i_ret0_cancel),
    .i_ret1_aligned  (ret1_aligned),
    .i_ret1_head_hit (ret1_head_hit),
    .i_ret1_bypass   (ret1_bypass),
    .i_ret1_cancel   (i_ret1_cancel),
    .o_rd_id         (o_rd_id),
    .o_rd_is_load    (o_rd_is_load),
    .o_rd_rd         (o_rd_rd),
    .o_rd_data       (o_rd_data),
    .o_rd_exc        (o_rd_exc),
    .o_data_ready    (o_data_ready),
    .o_fwd_vld       (o_fwd_vld),
    .o_fwd_id        (o_fwd_id),
    .o_fwd_data      (o_fwd_data)
  );

endmodule

// ==== hdl/load_queue_pkg.sv ====
// load queue types for the entry data word and its load and result views
`include "load_queue_consts.svh"

package load_queue_pkg;

  // load view holds the size and low address bits from execute
  // and later the data field from the memory return
  typedef struct packed {
    logic [`LQ_SZ_W-1:0]   sz;
    logic [1:0]            spare;
    logic [`LQ_OFS_W-1:0]  ofs;
    logic [`LQ_DATA_W-1:0] data;
  } lq_load_view_t;

  // view for any other instruction
  typedef struct packed {
    logic [1:0]            spare;
    logic [`LQ_EXC_W-1:0]  exc;   // sits over ofs, spare and sz[0] of the load view
    logic [`LQ_DATA_W-1:0] data;
  } lq_result_view_t;

  typedef union packed {
    lq_load_view_t   ld;
    lq_result_view_t res;
  } lq_word_u;

endpackage

// ==== hdl/lq_entry_array.sv ====
// load queue entry storage: tags, data words and per-entry valid bits
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module lq_entry_array (
  input  logic                                          i_clk,
  input  logic                                          i_reset_n,
  // tag write at allocation
  input  logic                                          i_alloc,
  input  logic [`LQ_ID_W-1:0]                           i_wr_idx,
  input  logic                                          i_alloc_is_load,
  input  logic [`LQ_RD_W-1:0]                           i_alloc_rd,
  // execute data write
  input  logic                                          i_ex_vld,
  input  logic [`LQ_ID_W-1:0]                           i_ex_id,
  input  load_queue_pkg::lq_word_u                      i_ex_word,
  // memory return stores, data field only
  input  logic                                          i_ret0_store,
  input  logic [`LQ_ID_W-1:0]                           i_ret0_id,
  input  logic [`LQ_DATA_W-1:0]                         i_ret0_data,
  input  logic                                          i_ret1_store,
  input  logic [`LQ_ID_W-1:0]                           i_ret1_id,
  input  logic [`LQ_DATA_W-1:0]                         i_ret1_data,
  // head release
  input  logic                                          i_clear,
  input  logic [`LQ_ID_W-1:0]                           i_rd_idx,
  output logic [`LQ_DEPTH-1:0]                          o_is_load,
  output load_queue_pkg::lq_word_u [`LQ_DEPTH-1:0]      o_word,
  output logic [`LQ_DEPTH-1:0][`LQ_RD_W-1:0]            o_rd,
  output logic [`LQ_DEPTH-1:0]                          o_data_valid
);

  for (genvar i = 0; i < `LQ_DEPTH; i++) begin : g_entry
    logic                     tag_vld;
    logic                     data_vld;
    logic                     is_load;
    logic [`LQ_RD_W-1:0]      rd;
    load_queue_pkg::lq_word_u word;

    logic alloc_hit;
    logic clear_hit;
    logic ex_hit;
    logic ret0_hit;
    logic ret1_hit;
    logic set_data_vld;

    assign alloc_hit = i_alloc & (i_wr_idx == `LQ_ID_W'(i));
    assign clear_hit = i_clear & (i_rd_idx == `LQ_ID_W'(i));
    assign ex_hit    = i_ex_vld & (i_ex_id == `LQ_ID_W'(i));
    assign ret0_hit  = i_ret0_store & (i_ret0_id == `LQ_ID_W'(i));
    assign ret1_hit  = i_ret1_store & (i_ret1_id == `LQ_ID_W'(i));

    // a load only becomes ready once its memory data is in
    assign set_data_vld = (ex_hit & ~is_load) | ret0_hit | ret1_hit;

    always_ff @(posedge i_clk) begin
      if (!i_reset_n) begin
        tag_vld  <= 1'b0;
        data_vld <= 1'b0;
      end else begin
        if (clear_hit) begin
          tag_vld <= 1'b0; // clear dominates set
        end else if (alloc_hit) begin
          tag_vld <= 1'b1;
        end
        if (clear_hit | alloc_hit) begin
          data_vld <= 1'b0;
        end else if (set_data_vld) begin
          data_vld <= 1'b1;
        end
      end
    end

    // payload
    always_ff @(posedge i_clk) begin
      if (alloc_hit) begin
        is_load <= i_alloc_is_load;
        rd      <= i_alloc_rd;
      end
      if (ex_hit) begin
        word <= i_ex_word;
      end else if (ret0_hit) begin
        word.ld.data <= i_ret0_data; // size and offset are kept
      end else if (ret1_hit) begin
        word.ld.data <= i_ret1_data;
      end
    end

    assign o_is_load[i]    = is_load;
    assign o_word[i]       = word;
    assign o_rd[i]         = rd;
    assign o_data_valid[i] = data_vld;

    a_write_needs_tag : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      (ex_hit | ret0_hit | ret1_hit) |-> tag_vld
    ) else $error("lq data write to entry %0d with tag not valid", i);
  end

endmodule

// ==== hdl/lq_load_align.sv ====
// load return alignment: byte and half select, then sign, zero or NaN-box extension
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module lq_load_align (
  input  logic [`LQ_DATA_W-1:0] i_data,
  input  logic [`LQ_SZ_W-1:0]   i_sz,
  input  logic [`LQ_OFS_W-1:0]  i_addr,
  output logic [`LQ_DATA_W-1:0] o_data
);

  logic [7:0]  byte_data;
  logic [15:0] half_data;

  assign byte_data = i_data[8*i_addr +: 8];     // byte lane by addr[1:0]
  assign half_data = i_data[16*i_addr[1] +: 16]; // half lane by addr[1]

  always_comb begin
    case (i_sz)
      `SZ_SB: begin
        o_data = {{(`LQ_DATA_W-8){byte_data[7]}}, byte_data};
      end
      `SZ_SH: begin
        o_data = {{(`LQ_DATA_W-16){half_data[15]}}, half_data};
      end
      `SZ_UB: begin
        o_data = {{(`LQ_DATA_W-8){1'b0}}, byte_data};
      end
      `SZ_UH: begin
        o_data = {{(`LQ_DATA_W-16){1'b0}}, half_data};
      end
      `SZ_HNB: begin
        o_data = {{(`LQ_DATA_W-16){1'b1}}, half_data}; // fp16 in a 32-bit register
      end
      `SZ_W: begin
        o_data = i_data;
      end
      default: begin
        o_data = i_data; // not a legal code, pass as a word
      end
    endcase
  end

endmodule

// ==== hdl/lq_pointers.sv ====
// load queue allocation and head pointers with full and empty flags
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module lq_pointers (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_alloc,
  input  logic                i_lq_rden,
  output logic [`LQ_ID_W-1:0] o_wr_idx,
  output logic [`LQ_ID_W-1:0] o_rd_idx,
  output logic                o_full,
  output logic                o_empty
);

  // one extra wrap bit on each pointer
  logic [`LQ_ID_W:0] wr_ptr;
  logic [`LQ_ID_W:0] rd_ptr;
  logic              idx_equal;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_alloc) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_lq_rden) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign idx_equal = (wr_ptr[`LQ_ID_W-1:0] == rd_ptr[`LQ_ID_W-1:0]);
  assign o_empty   = idx_equal & (wr_ptr[`LQ_ID_W] == rd_ptr[`LQ_ID_W]);
  assign o_full    = idx_equal & (wr_ptr[`LQ_ID_W] != rd_ptr[`LQ_ID_W]);

  assign o_wr_idx = wr_ptr[`LQ_ID_W-1:0]; // next id handed to the core
  assign o_rd_idx = rd_ptr[`LQ_ID_W-1:0];

  // no back-pressure, so overflow and underflow are core errors
  a_no_overflow : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_alloc && o_full) |-> i_lq_rden
  ) else $error("lq allocation while full without a read");

  a_no_underflow : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_lq_rden |-> !o_empty
  ) else $error("lq read while empty");

endmodule

// ==== hdl/lq_read_port.sv ====
// load queue head readout with return bypass and register-file forward
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module lq_read_port (
  input  logic [`LQ_ID_W-1:0]                       i_rd_idx,
  input  logic [`LQ_DEPTH-1:0]                      i_is_load,
  input  load_queue_pkg::lq_word_u [`LQ_DEPTH-1:0]  i_word,
  input  logic [`LQ_DEPTH-1:0][`LQ_RD_W-1:0]        i_rd,
  input  logic [`LQ_DEPTH-1:0]                      i_data_valid,
  input  logic [`LQ_DATA_W-1:0]                     i_ret0_aligned,
  input  logic                                      i_ret0_head_hit,
  input  logic                                      i_ret0_bypass,
  input  logic                                      i_ret0_cancel,
  input  logic [`LQ_DATA_W-1:0]                     i_ret1_aligned,
  input  logic                                      i_ret1_head_hit,
  input  logic                                      i_ret1_bypass,
  input  logic                                      i_ret1_cancel,
  output logic [`LQ_ID_W-1:0]                       o_rd_id,
  output logic                                      o_rd_is_load,
  output logic [`LQ_RD_W-1:0]                       o_rd_rd,
  output logic [`LQ_DATA_W-1:0]                     o_rd_data,
  output logic [`LQ_EXC_W-1:0]                      o_rd_exc,
  output logic                                      o_data_ready,
  output logic                                      o_fwd_vld,
  output logic [`LQ_ID_W-1:0]                       o_fwd_id,
  output logic [`LQ_DATA_W-1:0]                     o_fwd_data
);

  load_queue_pkg::lq_word_u head_word;
  logic                     any_bypass;
  logic [`LQ_DATA_W-1:0]    bypass_data;

  assign head_word = i_word[i_rd_idx];

  // at most one port can target the head, so and-or muxing is enough
  assign any_bypass  = i_ret0_bypass | i_ret1_bypass;
  assign bypass_data = ({`LQ_DATA_W{i_ret0_bypass}} & i_ret0_aligned) |
                       ({`LQ_DATA_W{i_ret1_bypass}} & i_ret1_aligned);

  assign o_rd_id      = i_rd_idx;
  assign o_rd_is_load = i_is_load[i_rd_idx];
  assign o_rd_rd      = i_rd[i_rd_idx];

  assign o_rd_data = any_bypass ? bypass_data : head_word.res.data;
  assign o_rd_exc  = any_bypass ? '0 : head_word.res.exc; // memory data carries no flags

  assign o_data_ready = i_data_valid[i_rd_idx] | any_bypass;

  // forward ignores bypass_disable; any cancel kills it late for timing
  assign o_fwd_vld  = (i_ret0_head_hit | i_ret1_head_hit) &
                      ~(i_ret0_cancel | i_ret1_cancel);
  assign o_fwd_id   = i_rd_idx;
  assign o_fwd_data = ({`LQ_DATA_W{i_ret0_head_hit}} & i_ret0_aligned) |
                      ({`LQ_DATA_W{i_ret1_head_hit}} & i_ret1_aligned);

endmodule

// ==== hdl/lq_return_path.sv ====
// one memory return port: alignment, head match, bypass and store decision
`timescale 1ns/1ps
`include "load_queue_consts.svh"

module lq_return_path (
  input  logic                     i_vld,
  input  logic                     i_cancel,
  input  logic [`LQ_ID_W-1:0]      i_id,
  input  logic [`LQ_DATA_W-1:0]    i_data,
  input  logic                     i_bypass_disable,
  // queue state seen by this return
  input  logic [`LQ_ID_W-1:0]      i_rd_idx,
  input  load_queue_pkg::lq_word_u i_word,    // word stored at i_id
  input  logic                     i_is_load, // load flag of entry i_id
  output logic [`LQ_DATA_W-1:0]    o_aligned,
  output logic                     o_head_hit,
  output logic                     o_bypass,
  output logic                     o_store
);

  logic load_ret;

  // returns only make sense for load entries
  assign load_ret = i_vld & i_is_load;

  lq_load_align u_align (
    .i_data (i_data),
    .i_sz   (i_word.ld.sz),
    .i_addr (i_word.ld.ofs),
    .o_data (o_aligned)
  );

  // cancel is left out here, the forward applies it late
  assign o_head_hit = load_ret & (i_id == i_rd_idx);

  assign o_bypass = o_head_hit & ~i_cancel & ~i_bypass_disable;

  // a bypassed return goes straight to the head reader, not into storage
  assign o_store = load_ret & ~i_cancel & ~o_bypass;

endmodule

// ==== include/load_queue_consts.svh ====
// load queue constants: depth, widths and load size codes
`ifndef LOAD_QUEUE_CONSTS_SVH
`define LOAD_QUEUE_CONSTS_SVH

`define LQ_DEPTH   8  // power of two
`define LQ_ID_W    3  // log2 of depth
`define LQ_DATA_W  32
`define LQ_WORD_W  39 // data plus 7 upper bits
`define LQ_RD_W    5
`define LQ_EXC_W   5
`define LQ_SZ_W    3
`define LQ_OFS_W   2

// load size codes held in the load view
`define SZ_SB   3'b000 // signed byte
`define SZ_SH   3'b001 // signed half
`define SZ_W    3'b010
`define SZ_UB   3'b100 // unsigned byte
`define SZ_UH   3'b101 // unsigned half
`define SZ_HNB  3'b110 // half, NaN boxed

`endif

// ==== load_queue.f ====
+incdir+include
hdl/load_queue_pkg.sv
hdl/lq_pointers.sv
hdl/lq_entry_array.sv
hdl/lq_load_align.sv
hdl/lq_return_path.sv
hdl/lq_read_port.sv
hdl/load_queue.sv
bench/load_queue_tb.sv
